/* include/dispatch_settings.svh */
// Widths and queue sizes of the four-wide dispatch stage.
// Count inputs are one bit wider than the matching index width.
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Bundle shape
`define DISPATCH_WIDTH 4
`define CHECKPOINTS 8
`define CHECKPOINTS_LOG 3

// Per-lane field widths
`define SIZE_PC 32
`define SIZE_RMT_LOG 5
`define SIZE_PHYSICAL_LOG 7
`define SIZE_OPCODE 8

// Back-end queue sizes; each count port is [*_LOG:0]
`define SIZE_LSQ 16
`define SIZE_LSQ_LOG 4
`define SIZE_ISSUEQ 32
`define SIZE_ISSUEQ_LOG 5
`define SIZE_ACTIVELIST 64
`define SIZE_ACTIVELIST_LOG 6

`endif

/* logic/maskPkg.sv */
// Branch checkpoint helpers shared by the holding latch and the router.
`include "dispatch_settings.svh"

package maskPkg;

  // Drops checkpoint id from a branch mask once its control instruction verifies
  function automatic logic [`CHECKPOINTS-1:0] clearResolved(
    input logic [`CHECKPOINTS-1:0]     mask,
    input logic                        verify,
    input logic [`CHECKPOINTS_LOG-1:0] id
  );
    logic [`CHECKPOINTS-1:0] result;
    result = mask;
    if (verify) begin
      result[id] = 1'b0;
    end
    return result;
  endfunction

endpackage

/* logic/capacityPkg.sv */
// Queue occupancy helpers for the dispatch room check.
// Counts are plain integers, so every queue size shares one function.
`include "dispatch_settings.svh"

package capacityPkg;

  // Width that holds any count from 0 up to DISPATCH_WIDTH
  localparam int CntWidth = $clog2(`DISPATCH_WIDTH + 1);

  // Number of lanes whose flag is set
  function automatic logic [CntWidth-1:0] countFlags(
    input logic [`DISPATCH_WIDTH-1:0] flags
  );
    logic [CntWidth-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      cnt = cnt + CntWidth'(flags[i]);
    end
    return cnt;
  endfunction

  // True when the queue can take every incoming entry
  function automatic logic hasRoom(
    input int unsigned count,
    input int unsigned incoming,
    input int unsigned size
  );
    return (count + incoming) <= size;
  endfunction

endpackage

/* logic/dispatchLatch.sv */
// One-bundle Rename/Dispatch register with a valid/ready handshake.
// A bundle that rename offers during a recovery is refused (ready is low).
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchLatch import maskPkg::*; (
  input  logic                          clk,
  input  logic                          rstN_i,
  input  logic                          renameValid_i,
  input  logic                          fire_i,
  input  logic                          flagRecoverEX_i,
  input  logic                          ctrlVerified_i,
  input  logic [`CHECKPOINTS_LOG-1:0]   ctrlVerifiedId_i,
  input  logic [`SIZE_PC-1:0]           pc_i         [`DISPATCH_WIDTH],
  input  logic [`SIZE_RMT_LOG-1:0]      logDest_i    [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0] phyDest_i    [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1_i    [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2_i    [`DISPATCH_WIDTH],
  input  logic [`SIZE_OPCODE-1:0]       opcode_i     [`DISPATCH_WIDTH],
  input  logic                          isLoad_i     [`DISPATCH_WIDTH],
  input  logic                          isStore_i    [`DISPATCH_WIDTH],
  input  logic [`CHECKPOINTS-1:0]       branchMask_i [`DISPATCH_WIDTH],
  output logic                          full_o,
  output logic                          ready_o,
  output logic [`SIZE_PC-1:0]           pc_o         [`DISPATCH_WIDTH],
  output logic [`SIZE_RMT_LOG-1:0]      logDest_o    [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0] phyDest_o    [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1_o    [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2_o    [`DISPATCH_WIDTH],
  output logic [`SIZE_OPCODE-1:0]       opcode_o     [`DISPATCH_WIDTH],
  output logic                          isLoad_o     [`DISPATCH_WIDTH],
  output logic                          isStore_o    [`DISPATCH_WIDTH],
  output logic [`CHECKPOINTS-1:0]       branchMask_o [`DISPATCH_WIDTH]
);

  logic load;

  // The slot opens when it is empty or its bundle leaves this cycle
  assign ready_o = (~full_o | fire_i) & ~flagRecoverEX_i;
  assign load    = renameValid_i & ready_o;

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      full_o <= 1'b0;
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        isLoad_o[i]  <= 1'b0;
        isStore_o[i] <= 1'b0;
      end
    end else begin
      if (flagRecoverEX_i) begin
        full_o <= 1'b0;
      end else if (load) begin
        full_o <= 1'b1;
      end else if (fire_i) begin
        full_o <= 1'b0;
      end
      if (load) begin
        isLoad_o  <= isLoad_i;
        isStore_o <= isStore_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (load) begin
        pc_o[i]         <= pc_i[i];
        logDest_o[i]    <= logDest_i[i];
        phyDest_o[i]    <= phyDest_i[i];
        phySrc1_o[i]    <= phySrc1_i[i];
        phySrc2_o[i]    <= phySrc2_i[i];
        opcode_o[i]     <= opcode_i[i];
        branchMask_o[i] <= branchMask_i[i];
      end else if (full_o) begin
        // A stalled bundle must not keep a checkpoint that has already resolved
        branchMask_o[i] <= clearResolved(branchMask_o[i], ctrlVerified_i, ctrlVerifiedId_i);
      end
    end
  end

  // The top level may only dispatch a bundle that is actually held
  fireNeedsBundle: assert property (@(posedge clk) disable iff (!rstN_i) fire_i |-> full_o)
    else $error("dispatch fired while the holding latch was empty");

endmodule

/* logic/capacityCheck.sv */
// Decides whether the back end can take the whole held bundle.
// Issue queue and active list always reserve a full bundle of entries.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module capacityCheck import capacityPkg::*; (
  input  logic                            isLoad_i  [`DISPATCH_WIDTH],
  input  logic                            isStore_i [`DISPATCH_WIDTH],
  input  logic [`SIZE_LSQ_LOG:0]          loadQueueCnt_i,
  input  logic [`SIZE_LSQ_LOG:0]          storeQueueCnt_i,
  input  logic [`SIZE_ISSUEQ_LOG:0]       issueQueueCnt_i,
  input  logic [`SIZE_ACTIVELIST_LOG:0]   activeListCnt_i,
  output logic                            fits_o
);

  logic [`DISPATCH_WIDTH-1:0] loadVec;
  logic [`DISPATCH_WIDTH-1:0] storeVec;
  logic [CntWidth-1:0]        loadCnt;
  logic [CntWidth-1:0]        storeCnt;

  always_comb begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      loadVec[i]  = isLoad_i[i];
      storeVec[i] = isStore_i[i];
    end
  end

  // Real counts, since several loads or stores can share one bundle
  assign loadCnt  = countFlags(loadVec);
  assign storeCnt = countFlags(storeVec);

  assign fits_o = hasRoom(loadQueueCnt_i, loadCnt, `SIZE_LSQ)
                & hasRoom(storeQueueCnt_i, storeCnt, `SIZE_LSQ)
                & hasRoom(issueQueueCnt_i, `DISPATCH_WIDTH, `SIZE_ISSUEQ)
                & hasRoom(activeListCnt_i, `DISPATCH_WIDTH, `SIZE_ACTIVELIST);

  // A lane takes one LSQ entry at most, so the two counts never overlap
  always_comb begin
    assert ((loadVec & storeVec) == '0)
      else $error("lane flagged as both load and store");
  end

endmodule

/* logic/packetRouter.sv */
// Fans each held lane out to the issue queue, active list and LSQ.
// Purely combinational; the verify clear reaches the outputs at once.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module packetRouter import maskPkg::*; (
  input  logic [`SIZE_PC-1:0]           pc_i            [`DISPATCH_WIDTH],
  input  logic [`SIZE_RMT_LOG-1:0]      logDest_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0] phyDest_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_OPCODE-1:0]       opcode_i        [`DISPATCH_WIDTH],
  input  logic                          isLoad_i        [`DISPATCH_WIDTH],
  input  logic                          isStore_i       [`DISPATCH_WIDTH],
  input  logic [`CHECKPOINTS-1:0]       branchMask_i    [`DISPATCH_WIDTH],
  input  logic                          ctrlVerified_i,
  input  logic [`CHECKPOINTS_LOG-1:0]   ctrlVerifiedId_i,
  output logic [`SIZE_OPCODE-1:0]       iqOpcode_o      [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0] iqPhySrc1_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0] iqPhySrc2_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0] iqPhyDest_o     [`DISPATCH_WIDTH],
  output logic [`CHECKPOINTS-1:0]       iqBranchMask_o  [`DISPATCH_WIDTH],
  output logic                          iqIsLoad_o      [`DISPATCH_WIDTH],
  output logic                          iqIsStore_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PC-1:0]           alPc_o          [`DISPATCH_WIDTH],
  output logic [`SIZE_RMT_LOG-1:0]      alLogDest_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0] alPhyDest_o     [`DISPATCH_WIDTH],
  output logic                          alIsLoad_o      [`DISPATCH_WIDTH],
  output logic                          alIsStore_o     [`DISPATCH_WIDTH],
  output logic [`CHECKPOINTS-1:0]       lsqBranchMask_o [`DISPATCH_WIDTH],
  output logic                          lsqIsLoad_o     [`DISPATCH_WIDTH],
  output logic                          lsqIsStore_o    [`DISPATCH_WIDTH]
);

  logic [`CHECKPOINTS-1:0] laneMask [`DISPATCH_WIDTH];

  always_comb begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      // One cleared mask per lane feeds both the issue queue and the LSQ
      laneMask[i] = clearResolved(branchMask_i[i], ctrlVerified_i, ctrlVerifiedId_i);

      iqOpcode_o[i]     = opcode_i[i];
      iqPhySrc1_o[i]    = phySrc1_i[i];
      iqPhySrc2_o[i]    = phySrc2_i[i];
      iqPhyDest_o[i]    = phyDest_i[i];
      iqBranchMask_o[i] = laneMask[i];
      iqIsLoad_o[i]     = isLoad_i[i];
      iqIsStore_o[i]    = isStore_i[i];

      // The active list keeps what retirement needs to free the old mapping
      alPc_o[i]      = pc_i[i];
      alLogDest_o[i] = logDest_i[i];
      alPhyDest_o[i] = phyDest_i[i];
      alIsLoad_o[i]  = isLoad_i[i];
      alIsStore_o[i] = isStore_i[i];

      lsqBranchMask_o[i] = laneMask[i];
      lsqIsLoad_o[i]     = isLoad_i[i];
      lsqIsStore_o[i]    = isStore_i[i];
    end
  end

endmodule

/* logic/dispatchStage.sv */
// Dispatch stage top: holding latch, room check and back-end routing.
// Back-end queues push back only through their occupancy counts.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchStage (
  input  logic                            clk,
  input  logic                            rstN_i,
  input  logic                            renameValid_i,
  input  logic [`SIZE_PC-1:0]             pc_i            [`DISPATCH_WIDTH],
  input  logic [`SIZE_RMT_LOG-1:0]        logDest_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0]   phyDest_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0]   phySrc1_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_PHYSICAL_LOG-1:0]   phySrc2_i       [`DISPATCH_WIDTH],
  input  logic [`SIZE_OPCODE-1:0]         opcode_i        [`DISPATCH_WIDTH],
  input  logic                            isLoad_i        [`DISPATCH_WIDTH],
  input  logic                            isStore_i       [`DISPATCH_WIDTH],
  input  logic [`CHECKPOINTS-1:0]         branchMask_i    [`DISPATCH_WIDTH],
  input  logic                            flagRecoverEX_i,
  input  logic                            ctrlVerified_i,
  input  logic [`CHECKPOINTS_LOG-1:0]     ctrlVerifiedId_i,
  input  logic [`SIZE_LSQ_LOG:0]          loadQueueCnt_i,
  input  logic [`SIZE_LSQ_LOG:0]          storeQueueCnt_i,
  input  logic [`SIZE_ISSUEQ_LOG:0]       issueQueueCnt_i,
  input  logic [`SIZE_ACTIVELIST_LOG:0]   activeListCnt_i,
  output logic                            dispatchReady_o,
  output logic                            dispatchValid_o,
  output logic                            stallFrontEnd_o,
  output logic [`SIZE_OPCODE-1:0]         iqOpcode_o      [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0]   iqPhySrc1_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0]   iqPhySrc2_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0]   iqPhyDest_o     [`DISPATCH_WIDTH],
  output logic [`CHECKPOINTS-1:0]         iqBranchMask_o  [`DISPATCH_WIDTH],
  output logic                            iqIsLoad_o      [`DISPATCH_WIDTH],
  output logic                            iqIsStore_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PC-1:0]             alPc_o          [`DISPATCH_WIDTH],
  output logic [`SIZE_RMT_LOG-1:0]        alLogDest_o     [`DISPATCH_WIDTH],
  output logic [`SIZE_PHYSICAL_LOG-1:0]   alPhyDest_o     [`DISPATCH_WIDTH],
  output logic                            alIsLoad_o      [`DISPATCH_WIDTH],
  output logic                            alIsStore_o     [`DISPATCH_WIDTH],
  output logic [`CHECKPOINTS-1:0]         lsqBranchMask_o [`DISPATCH_WIDTH],
  output logic                            lsqIsLoad_o     [`DISPATCH_WIDTH],
  output logic                            lsqIsStore_o    [`DISPATCH_WIDTH]
);

  logic                          full;
  logic                          fits;
  logic                          fire;
  logic [`SIZE_PC-1:0]           heldPc      [`DISPATCH_WIDTH];
  logic [`SIZE_RMT_LOG-1:0]      heldLogDest [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0] heldPhyDest [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0] heldPhySrc1 [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0] heldPhySrc2 [`DISPATCH_WIDTH];
  logic [`SIZE_OPCODE-1:0]       heldOpcode  [`DISPATCH_WIDTH];
  logic                          heldIsLoad  [`DISPATCH_WIDTH];
  logic                          heldIsStore [`DISPATCH_WIDTH];
  logic [`CHECKPOINTS-1:0]       heldMask    [`DISPATCH_WIDTH];

  // Whole bundles only; a recovery squashes the held bundle in place
  assign fire            = full & fits & ~flagRecoverEX_i;
  assign dispatchValid_o = fire;
  assign stallFrontEnd_o = full & ~fits;

  dispatchLatch latch (
    .clk(clk), .rstN_i(rstN_i), .renameValid_i(renameValid_i), .fire_i(fire),
    .flagRecoverEX_i(flagRecoverEX_i), .ctrlVerified_i(ctrlVerified_i),
    .ctrlVerifiedId_i(ctrlVerifiedId_i), .pc_i(pc_i), .logDest_i(logDest_i),
    .phyDest_i(phyDest_i), .phySrc1_i(phySrc1_i), .phySrc2_i(phySrc2_i),
    .opcode_i(opcode_i), .isLoad_i(isLoad_i), .isStore_i(isStore_i),
    .branchMask_i(branchMask_i), .full_o(full), .ready_o(dispatchReady_o),
    .pc_o(heldPc), .logDest_o(heldLogDest), .phyDest_o(heldPhyDest),
    .phySrc1_o(heldPhySrc1), .phySrc2_o(heldPhySrc2), .opcode_o(heldOpcode),
    .isLoad_o(heldIsLoad), .isStore_o(heldIsStore), .branchMask_o(heldMask)
  );

  capacityCheck check (
    .isLoad_i(heldIsLoad), .isStore_i(heldIsStore), .loadQueueCnt_i(loadQueueCnt_i),
    .storeQueueCnt_i(storeQueueCnt_i), .issueQueueCnt_i(issueQueueCnt_i),
    .activeListCnt_i(activeListCnt_i), .fits_o(fits)
  );

  packetRouter router (
    .pc_i(heldPc), .logDest_i(heldLogDest), .phyDest_i(heldPhyDest),
    .phySrc1_i(heldPhySrc1), .phySrc2_i(heldPhySrc2), .opcode_i(heldOpcode),
    .isLoad_i(heldIsLoad), .isStore_i(heldIsStore), .branchMask_i(heldMask),
    .ctrlVerified_i(ctrlVerified_i), .ctrlVerifiedId_i(ctrlVerifiedId_i),
    .iqOpcode_o(iqOpcode_o), .iqPhySrc1_o(iqPhySrc1_o), .iqPhySrc2_o(iqPhySrc2_o),
    .iqPhyDest_o(iqPhyDest_o), .iqBranchMask_o(iqBranchMask_o),
    .iqIsLoad_o(iqIsLoad_o), .iqIsStore_o(iqIsStore_o), .alPc_o(alPc_o),
    .alLogDest_o(alLogDest_o), .alPhyDest_o(alPhyDest_o), .alIsLoad_o(alIsLoad_o),
    .alIsStore_o(alIsStore_o), .lsqBranchMask_o(lsqBranchMask_o),
    .lsqIsLoad_o(lsqIsLoad_o), .lsqIsStore_o(lsqIsStore_o)
  );

  noDispatchOnRecovery: assert property (@(posedge clk) disable iff (!rstN_i)
    !(dispatchValid_o && flagRecoverEX_i))
    else $error("bundle dispatched during a recovery");

endmodule

/* tb/dispatchStage_tb.sv */
// Table-driven self-checking testbench for the dispatch stage.
// Each table row is one clock cycle; lane fields not fixed by the table come from an LCG.
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatchStage_tb;

  localparam int NumSteps     = 27;
  localparam int TimeoutLimit = NumSteps * 4 + 20;

  // One cycle of stimulus and the handshake outputs expected in that cycle
  typedef struct {
    logic                       rv;
    logic [`DISPATCH_WIDTH-1:0] ld;
    logic [`DISPATCH_WIDTH-1:0] st;
    int                         lqc;
    int                         sqc;
    int                         iqc;
    int                         alc;
    logic                       ver;
    int                         vid;
    logic                       rec;
    logic [`CHECKPOINTS-1:0]    setBits;
    logic                       expV;
    logic                       expS;
    logic                       expR;
  } stepRow;

  logic                            clk;
  logic                            rstN_i;
  logic                            renameValid_i;
  logic [`SIZE_PC-1:0]             pc_i            [`DISPATCH_WIDTH];
  logic [`SIZE_RMT_LOG-1:0]        logDest_i       [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0]   phyDest_i       [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0]   phySrc1_i       [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0]   phySrc2_i       [`DISPATCH_WIDTH];
  logic [`SIZE_OPCODE-1:0]         opcode_i        [`DISPATCH_WIDTH];
  logic                            isLoad_i        [`DISPATCH_WIDTH];
  logic                            isStore_i       [`DISPATCH_WIDTH];
  logic [`CHECKPOINTS-1:0]         branchMask_i    [`DISPATCH_WIDTH];
  logic                            flagRecoverEX_i;
  logic                            ctrlVerified_i;
  logic [`CHECKPOINTS_LOG-1:0]     ctrlVerifiedId_i;
  logic [`SIZE_LSQ_LOG:0]          loadQueueCnt_i;
  logic [`SIZE_LSQ_LOG:0]          storeQueueCnt_i;
  logic [`SIZE_ISSUEQ_LOG:0]       issueQueueCnt_i;
  logic [`SIZE_ACTIVELIST_LOG:0]   activeListCnt_i;
  logic                            dispatchReady_o;
  logic                            dispatchValid_o;
  logic                            stallFrontEnd_o;
  logic [`SIZE_OPCODE-1:0]         iqOpcode_o      [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0]   iqPhySrc1_o     [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0]   iqPhySrc2_o     [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0]   iqPhyDest_o     [`DISPATCH_WIDTH];
  logic [`CHECKPOINTS-1:0]         iqBranchMask_o  [`DISPATCH_WIDTH];
  logic                            iqIsLoad_o      [`DISPATCH_WIDTH];
  logic                            iqIsStore_o     [`DISPATCH_WIDTH];
  logic [`SIZE_PC-1:0]             alPc_o          [`DISPATCH_WIDTH];
  logic [`SIZE_RMT_LOG-1:0]        alLogDest_o     [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0]   alPhyDest_o     [`DISPATCH_WIDTH];
  logic                            alIsLoad_o      [`DISPATCH_WIDTH];
  logic                            alIsStore_o     [`DISPATCH_WIDTH];
  logic [`CHECKPOINTS-1:0]         lsqBranchMask_o [`DISPATCH_WIDTH];
  logic                            lsqIsLoad_o     [`DISPATCH_WIDTH];
  logic                            lsqIsStore_o    [`DISPATCH_WIDTH];

  // Bundle that the latch is expected to hold
  logic [`SIZE_PC-1:0]           modelPc      [`DISPATCH_WIDTH];
  logic [`SIZE_RMT_LOG-1:0]      modelLogDest [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0] modelPhyDest [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0] modelSrc1    [`DISPATCH_WIDTH];
  logic [`SIZE_PHYSICAL_LOG-1:0] modelSrc2    [`DISPATCH_WIDTH];
  logic [`SIZE_OPCODE-1:0]       modelOpcode  [`DISPATCH_WIDTH];
  logic                          modelLoad    [`DISPATCH_WIDTH];
  logic                          modelStore   [`DISPATCH_WIDTH];
  logic [`CHECKPOINTS-1:0]       modelMask    [`DISPATCH_WIDTH];

  stepRow      steps [NumSteps];
  int          stepCount;
  int          errCount;
  int          cycles;
  logic [31:0] seed;

  dispatchStage UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic addStep(input logic rv, input logic [3:0] ld, input logic [3:0] st,
                         input int lqc, input int sqc, input int iqc, input int alc,
                         input logic ver, input int vid, input logic rec,
                         input logic [7:0] setBits, input logic expV, input logic expS,
                         input logic expR);
    steps[stepCount] = '{rv, ld, st, lqc, sqc, iqc, alc, ver, vid, rec, setBits,
                         expV, expS, expR};
    stepCount++;
  endtask

  task automatic checkValue(input string what, input int lane, input logic [31:0] act,
                            input logic [31:0] exp);
    if (act !== exp) begin
      errCount++;
      $display("FAILED at %0t ns: %s lane %0d is %h, expected %h", $time, what, lane, act, exp);
      $display("*** FAILED ***");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // Applied with non-blocking assignments right after a rising edge
  task automatic driveStep(input stepRow s);
    logic [31:0] r;
    renameValid_i    <= s.rv;
    flagRecoverEX_i  <= s.rec;
    ctrlVerified_i   <= s.ver;
    ctrlVerifiedId_i <= `CHECKPOINTS_LOG'(s.vid);
    loadQueueCnt_i   <= (`SIZE_LSQ_LOG+1)'(s.lqc);
    storeQueueCnt_i  <= (`SIZE_LSQ_LOG+1)'(s.sqc);
    issueQueueCnt_i  <= (`SIZE_ISSUEQ_LOG+1)'(s.iqc);
    activeListCnt_i  <= (`SIZE_ACTIVELIST_LOG+1)'(s.alc);
    if (s.rv) begin
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        pc_i[i]         <= nextRand();
        r               = nextRand();
        logDest_i[i]    <= r[4:0];
        phyDest_i[i]    <= r[11:5];
        phySrc1_i[i]    <= r[18:12];
        phySrc2_i[i]    <= r[25:19];
        r               = nextRand();
        opcode_i[i]     <= r[7:0];
        branchMask_i[i] <= r[15:8] | s.setBits;
        isLoad_i[i]     <= s.ld[i];
        isStore_i[i]    <= s.st[i];
      end
    end
  endtask

  task automatic checkOutputs(input stepRow s);
    logic [`CHECKPOINTS-1:0] expMask;
    checkValue("dispatchValid_o", -1, dispatchValid_o, s.expV);
    checkValue("stallFrontEnd_o", -1, stallFrontEnd_o, s.expS);
    checkValue("dispatchReady_o", -1, dispatchReady_o, s.expR);
    if (s.expV || s.expS) begin
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        // A verify this cycle hides its checkpoint bit from the outgoing lanes
        expMask = modelMask[i];
        if (s.ver) expMask = expMask & ~(`CHECKPOINTS'(1) << s.vid);
        checkValue("iqOpcode_o", i, iqOpcode_o[i], modelOpcode[i]);
        checkValue("iqPhySrc1_o", i, iqPhySrc1_o[i], modelSrc1[i]);
        checkValue("iqPhySrc2_o", i, iqPhySrc2_o[i], modelSrc2[i]);
        checkValue("iqPhyDest_o", i, iqPhyDest_o[i], modelPhyDest[i]);
        checkValue("iqBranchMask_o", i, iqBranchMask_o[i], expMask);
        checkValue("iqIsLoad_o", i, iqIsLoad_o[i], modelLoad[i]);
        checkValue("iqIsStore_o", i, iqIsStore_o[i], modelStore[i]);
        checkValue("alPc_o", i, alPc_o[i], modelPc[i]);
        checkValue("alLogDest_o", i, alLogDest_o[i], modelLogDest[i]);
        checkValue("alPhyDest_o", i, alPhyDest_o[i], modelPhyDest[i]);
        checkValue("alIsLoad_o", i, alIsLoad_o[i], modelLoad[i]);
        checkValue("alIsStore_o", i, alIsStore_o[i], modelStore[i]);
        checkValue("lsqBranchMask_o", i, lsqBranchMask_o[i], expMask);
        checkValue("lsqIsLoad_o", i, lsqIsLoad_o[i], modelLoad[i]);
        checkValue("lsqIsStore_o", i, lsqIsStore_o[i], modelStore[i]);
      end
    end
  endtask

  // Mirrors what the latch does at the coming edge
  task automatic updateModel(input stepRow s);
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (s.rv && s.expR) begin
        modelPc[i]      = pc_i[i];
        modelLogDest[i] = logDest_i[i];
        modelPhyDest[i] = phyDest_i[i];
        modelSrc1[i]    = phySrc1_i[i];
        modelSrc2[i]    = phySrc2_i[i];
        modelOpcode[i]  = opcode_i[i];
        modelLoad[i]    = isLoad_i[i];
        modelStore[i]   = isStore_i[i];
        modelMask[i]    = branchMask_i[i];
      end else if (s.ver) begin
        modelMask[i] = modelMask[i] & ~(`CHECKPOINTS'(1) << s.vid);
      end
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < TimeoutLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the step table did not finish within %0d cycles", TimeoutLimit);
    $display("*** FAILED ***");
    $fatal(1, "simulation ran out of cycles");
  end

  initial begin
    seed = 32'h675e;
    errCount = 0;
    stepCount = 0;
    rstN_i = 1'b0;
    renameValid_i = 1'b0;
    flagRecoverEX_i = 1'b0;
    ctrlVerified_i = 1'b0;
    ctrlVerifiedId_i = '0;
    loadQueueCnt_i = '0;
    storeQueueCnt_i = '0;
    issueQueueCnt_i = '0;
    activeListCnt_i = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      pc_i[i] = '0;
      logDest_i[i] = '0;
      phyDest_i[i] = '0;
      phySrc1_i[i] = '0;
      phySrc2_i[i] = '0;
      opcode_i[i] = '0;
      isLoad_i[i] = 1'b0;
      isStore_i[i] = 1'b0;
      branchMask_i[i] = '0;
    end

    // rv  ld       st       lqc sqc iqc alc ver vid rec set    V  S  R
    addStep(1, 4'b0001, 4'b0010, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 1, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    // Loads against a load queue holding 14 entries
    addStep(1, 4'b0011, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    addStep(1, 4'b0111, 4'b0000, 14, 0, 0, 0, 0, 0, 0, 8'h00, 1, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 14, 0, 0, 0, 0, 0, 0, 8'h00, 0, 1, 0);
    addStep(0, 4'b0000, 4'b0000, 13, 0, 0, 0, 0, 0, 0, 8'h00, 1, 0, 1);
    // Same for stores
    addStep(1, 4'b0000, 4'b1100, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    addStep(1, 4'b0000, 4'b1110, 0, 14, 0, 0, 0, 0, 0, 8'h00, 1, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 14, 0, 0, 0, 0, 0, 8'h00, 0, 1, 0);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 1, 0, 1);
    // Issue queue, then active list, one entry short of a full bundle
    addStep(1, 4'b0000, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 29, 0, 0, 0, 0, 8'h00, 0, 1, 0);
    addStep(1, 4'b0000, 4'b0000, 0, 0, 29, 0, 0, 0, 0, 8'h00, 0, 1, 0);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 28, 0, 0, 0, 0, 8'h00, 1, 0, 1);
    addStep(1, 4'b0000, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 61, 0, 0, 0, 8'h00, 0, 1, 0);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 60, 0, 0, 0, 8'h00, 1, 0, 1);
    // Checkpoint 5 resolves while the bundle is stalled
    addStep(1, 4'b1000, 4'b0001, 0, 0, 0, 0, 0, 0, 0, 8'h20, 0, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 29, 0, 1, 5, 0, 8'h00, 0, 1, 0);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 29, 0, 0, 0, 0, 8'h00, 0, 1, 0);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 0, 1, 2, 0, 8'h00, 1, 0, 1);
    // Recovery squashes the held bundle and refuses the one on offer
    addStep(1, 4'b0100, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    addStep(1, 4'b0010, 4'b0000, 0, 0, 0, 0, 0, 0, 1, 8'h00, 0, 0, 0);
    addStep(1, 4'b0000, 4'b1000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 1, 0, 1);
    addStep(0, 4'b0000, 4'b0000, 0, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 1);

    repeat (4) @(posedge clk);
    rstN_i <= 1'b1;
    for (int r = 0; r < stepCount; r++) begin
      driveStep(steps[r]);
      @(negedge clk);
      checkOutputs(steps[r]);
      updateModel(steps[r]);
      @(posedge clk);
    end

    if (errCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
logic/maskPkg.sv
logic/capacityPkg.sv
logic/dispatchLatch.sv
logic/capacityCheck.sv
logic/packetRouter.sv
logic/dispatchStage.sv
tb/dispatchStage_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module dispatchStage_tb -o dispatchSim \
  && ./obj_dir/dispatchSim | tee /dev/stderr | grep -q -F '*** PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
